/* project.f */
+incdir+src
src/trace_pkg.sv
src/trace_regs.sv
src/trace_matcher.sv
src/trace_trigger.sv
src/event_fifo.sv
src/trace_top.sv
sim/trace_tb_properties.sv
sim/trace_tb.sv

/* Makefile */
TOP = trace_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f project.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* sim/trace_tb.sv */
`include "trace_cfg.svh"

module trace_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import trace_pkg::*;

  typedef struct packed {
    trace_buf_t word;
    logic       hit;    // row should hit a rule
    rule_id_t   rule;
  } row_t;

  localparam int NUM_ROWS = 8;
  localparam int TIMEOUT  = 200;  // cycles per wait

  localparam rule_cfg_t RULES [`MATCH_RULES] = '{
    '{32'hA5C39E17, 32'hFFFFFFFF},
    '{32'h6B2F84D9, 32'hFFFFFFFF},
    '{32'hDEAD0000, 32'hFFFF0000},  // upper half only, two words hit
    '{32'h13579BDF, 32'hFFFFFFFF}
  };

  localparam row_t ROWS [NUM_ROWS] = '{
    '{32'hA5C39E17, 1'b1, 2'd0},
    '{32'hDEAD1234, 1'b1, 2'd2},
    '{32'h12345678, 1'b0, 2'd0},
    '{32'h6B2F84D9, 1'b1, 2'd1},
    '{32'hDEADBEEF, 1'b1, 2'd2},
    '{32'h13579BDF, 1'b1, 2'd3},
    '{32'hA5C39E17, 1'b1, 2'd0},
    '{32'hCAFE0DAD, 1'b0, 2'd0}
  };

  localparam trig_delay_t PULSE_DELAY = 16'd3;
  localparam trig_width_t PULSE_WIDTH = 12'd5;

  logic          trace_clk = 1'b0;
  logic          reset;
  apb_req_t      apb;
  apb_rsp_t      apb_rsp;
  trace_nibble_t trace_data;
  logic          trig_out;
  logic          armed;

  int unsigned  cycle = 0;
  int unsigned  arm_cycle = 0;
  logic         armed_model;
  trace_buf_t   shadow;          // expected history contents
  match_count_t exp_count [`MATCH_RULES];
  event_t       exp_q [$];
  logic         exp_ovf;
  int           pulse_count = 0;
  int           high_len = 0;
  logic         trig_prev = 1'b0;

  trace_top uut (.*);

  always #2 trace_clk = ~trace_clk;

  always @(posedge trace_clk) cycle <= cycle + 1;

  // pulse counting mid-cycle, away from the edges
  always @(negedge trace_clk) begin
    if (!reset) begin
      if (trig_out && !trig_prev) begin
        pulse_count++;
        high_len = 0;
      end
      if (trig_out) begin
        high_len++;
      end
      trig_prev = trig_out;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input match_count_t exp,
                             input match_count_t act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act));
    end
  endtask

  task automatic check_event(input string name, input event_t exp, input event_t act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %0t %s expected id %0d ts %0d actual id %0d ts %0d",
                          $time, name, exp.rule_id, exp.timestamp, act.rule_id, act.timestamp));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  // entered and left 0.5 ns after a rising edge
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    int n;
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    apb.pwrite  = write;
    apb.paddr   = addr;
    apb.pwdata  = wdata;
    @(posedge trace_clk);
    #0.5;
    apb.penable = 1'b1;
    n = 0;
    @(negedge trace_clk);
    while (!apb_rsp.pready) begin
      n++;
      if (n > TIMEOUT) begin
        abort_run($sformatf("APB access to %h never saw pready", addr));
      end
      @(negedge trace_clk);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge trace_clk);
    #0.5;
    apb.psel    = 1'b0;
    apb.penable = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
    apb_data_t rdata;
    logic      err;
    apb_access(1'b1, addr, data, rdata, err);
    check_bit($sformatf("pslverr write %h", addr), exp_err, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, input logic exp_err);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_bit($sformatf("pslverr read %h", addr), exp_err, err);
  endtask

  task automatic feed_nibble(input trace_nibble_t n);
    trace_data = n;
    shadow     = {shadow[`TRACE_BUFFER_BITS-`TRACE_LANES-1:0], n};
    @(posedge trace_clk);
    #0.5;
  endtask

  function automatic logic window_hits(input trace_buf_t w);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `MATCH_RULES; i++) begin
      if ((w & RULES[i].mask) == (RULES[i].pattern & RULES[i].mask)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // random nibble that forms no rule match, even as zeros follow it
  function automatic trace_nibble_t pick_filler();
    trace_nibble_t n;
    trace_buf_t    hist;
    logic          clash;
    n     = '0;
    clash = 1'b1;
    for (int t = 0; t < 64 && clash; t++) begin
      n     = trace_nibble_t'($urandom);
      hist  = {shadow[`TRACE_BUFFER_BITS-`TRACE_LANES-1:0], n};
      clash = 1'b0;
      for (int k = 0; k < `TRACE_BUFFER_BITS / `TRACE_LANES; k++) begin
        clash = clash | window_hits(hist << (`TRACE_LANES * k));
      end
    end
    return n;
  endfunction

  task automatic set_arm(input logic on);
    apb_write(`REG_CTRL, apb_data_t'(on), 1'b0);
    if (on && !armed_model) begin
      arm_cycle = cycle;  // timestamp zero point
      exp_q.delete();
      exp_ovf = 1'b0;
      foreach (exp_count[i]) begin
        exp_count[i] = '0;
      end
    end
    armed_model = on;
    check_bit("armed", on, armed);
  endtask

  // word goes out msb nibble first, then 8 zeros flush it
  task automatic apply_row(input row_t r);
    event_t ev;
    for (int i = `TRACE_BUFFER_BITS / `TRACE_LANES - 1; i >= 0; i--) begin
      feed_nibble(r.word[`TRACE_LANES*i +: `TRACE_LANES]);
    end
    if (r.hit && armed_model) begin
      exp_count[r.rule] = exp_count[r.rule] + 1'b1;
      ev.rule_id   = r.rule;
      ev.timestamp = timestamp_t'(cycle - arm_cycle);
      if (exp_q.size() < `EVENT_FIFO_DEPTH) begin
        exp_q.push_back(ev);
      end else begin
        exp_ovf = 1'b1;  // full fifo drops it
      end
    end
    repeat (8) feed_nibble('0);
  endtask

  task automatic apply_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(ROWS[r]);
    end
  endtask

  task automatic check_counts();
    apb_data_t data;
    for (int i = 0; i < `MATCH_RULES; i++) begin
      apb_read(apb_addr_t'(`REG_COUNT_BASE + 4 * i), data, 1'b0);
      check_count($sformatf("count%0d", i), exp_count[i], match_count_t'(data));
    end
  endtask

  task automatic check_status();
    apb_data_t data;
    apb_read(`REG_STATUS, data, 1'b0);
    check_data("status.fifo_count", apb_data_t'(exp_q.size()), apb_data_t'(data[4:0]));
    check_bit("status.overflow", exp_ovf, data[8]);
  endtask

  task automatic pop_all();
    apb_data_t data;
    event_t    exp;
    int        n;
    n = exp_q.size();
    for (int k = 0; k < n; k++) begin
      exp = exp_q.pop_front();
      apb_read(`REG_FIFO_DATA, data, 1'b0);
      check_event($sformatf("fifo_data[%0d]", k), exp, event_t'(data[$bits(event_t)-1:0]));
    end
    check_status();
  endtask

  initial begin
    apb_data_t data;
    int        n;
    void'($urandom(32'h817bd7e7));
    reset       = 1'b1;
    apb         = '0;
    trace_data  = '0;
    armed_model = 1'b0;
    exp_ovf     = 1'b0;
    shadow      = '0;
    repeat (2) @(posedge trace_clk);
    #0.5;
    reset = 1'b0;
    repeat (8) feed_nibble('0);  // history has no reset

    // config readback, slave errors
    for (int i = 0; i < `MATCH_RULES; i++) begin
      apb_write(apb_addr_t'(`REG_PATTERN_BASE + 8 * i), RULES[i].pattern, 1'b0);
      apb_write(apb_addr_t'(`REG_MASK_BASE + 8 * i), RULES[i].mask, 1'b0);
    end
    apb_write(`REG_TRIG_DELAY, apb_data_t'(PULSE_DELAY), 1'b0);
    apb_write(`REG_TRIG_WIDTH, apb_data_t'(PULSE_WIDTH), 1'b0);
    for (int i = 0; i < `MATCH_RULES; i++) begin
      apb_read(apb_addr_t'(`REG_PATTERN_BASE + 8 * i), data, 1'b0);
      check_data($sformatf("pattern%0d", i), RULES[i].pattern, data);
      apb_read(apb_addr_t'(`REG_MASK_BASE + 8 * i), data, 1'b0);
      check_data($sformatf("mask%0d", i), RULES[i].mask, data);
    end
    apb_read(`REG_TRIG_DELAY, data, 1'b0);
    check_data("trig_delay", apb_data_t'(PULSE_DELAY), data);
    apb_read(`REG_TRIG_WIDTH, data, 1'b0);
    check_data("trig_width", apb_data_t'(PULSE_WIDTH), data);
    apb_read(8'h18, data, 1'b1);  // hole in the map
    apb_write(`REG_STATUS, 32'h1, 1'b1);

    // armed pass: filler must not hit, table rows must
    apb_write(`REG_RULE_EN, 32'h0000_000F, 1'b0);
    set_arm(1'b1);
    repeat (24) feed_nibble(pick_filler());
    repeat (8) feed_nibble('0);
    apply_table();
    check_counts();

    // disarmed pass leaves counters and fifo alone
    set_arm(1'b0);
    apply_table();
    check_counts();
    check_status();
    pop_all();
    apb_read(`REG_FIFO_DATA, data, 1'b0);
    check_data("fifo_data when empty", '0, data);

    // rule 1 may trigger
    apb_write(`REG_RULE_EN, 32'h0000_002F, 1'b0);
    set_arm(1'b1);
    check_counts();
    apply_row(ROWS[3]);
    n = 0;
    while (pulse_count == 0 || trig_out) begin
      @(posedge trace_clk);
      #0.5;
      n++;
      if (n > TIMEOUT) begin
        abort_run("trig_out pulse did not rise and fall in time");
      end
    end
    check_data("trig_out width", apb_data_t'(PULSE_WIDTH), apb_data_t'(high_len));
    apply_table();
    check_data("trig_out pulse count", 32'd1, apb_data_t'(pulse_count));
    apb_read(`REG_STATUS, data, 1'b0);
    check_bit("status.trig_done", 1'b1, data[9]);

    // 19 hits since arm, oldest 16 stay
    apply_table();
    apply_table();
    check_status();
    pop_all();

    set_arm(1'b0);
    set_arm(1'b1);
    apb_read(`REG_STATUS, data, 1'b0);
    check_data("status after re-arm", '0, data);
    check_counts();

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* sim/trace_tb_properties.sv */
`include "trace_cfg.svh"

module trace_tb_properties (
  input logic                               trace_clk,
  input logic                               reset,
  input trace_pkg::apb_req_t                apb,
  input trace_pkg::apb_rsp_t                apb_rsp,
  input logic [$clog2(`EVENT_FIFO_DEPTH):0] fifo_count,
  input logic                               trig_out,
  input trace_pkg::trig_state_e             trig_state
);
  timeunit 1ns;
  timeprecision 100ps;
  import trace_pkg::*;

  // no wait states ever
  pready_high: assert property (@(posedge trace_clk) disable iff (reset) apb_rsp.pready)
    else $error("pready went low");

  slverr_in_access: assert property (@(posedge trace_clk) disable iff (reset)
    apb_rsp.pslverr |-> (apb.psel && apb.penable))
    else $error("pslverr outside an access phase");

  fifo_bound: assert property (@(posedge trace_clk) disable iff (reset)
    fifo_count <= `EVENT_FIFO_DEPTH)
    else $error("fifo_count above depth");

  // pulse state only, and never entered straight from idle
  pulse_only: assert property (@(posedge trace_clk) disable iff (reset)
    trig_out |-> (trig_state == TRIG_PULSE) && ($past(trig_state) != TRIG_IDLE))
    else $error("trig_out high outside a pulse that followed the delay");

endmodule

bind trace_top trace_tb_properties props (
  .trace_clk  (trace_clk),
  .reset      (reset),
  .apb        (apb),
  .apb_rsp    (apb_rsp),
  .fifo_count (fifo_count),
  .trig_out   (trig_out),
  .trig_state (u_trigger.state)
);

/* src/trace_top.sv */
`include "trace_cfg.svh"

module trace_top (
  input  logic                     trace_clk,
  input  logic                     reset,
  input  trace_pkg::apb_req_t      apb,
  input  trace_pkg::trace_nibble_t trace_data,
  output trace_pkg::apb_rsp_t      apb_rsp,
  output logic                     trig_out,
  output logic                     armed
);
  import trace_pkg::*;

  rule_cfg_t [`MATCH_RULES-1:0]       rule_cfg;
  match_count_t [`MATCH_RULES-1:0]    counts;
  rule_mask_t                         rule_en;
  rule_mask_t                         trig_en;
  rule_mask_t                         match_hit;
  trig_delay_t                        trig_delay;
  trig_width_t                        trig_width;
  event_t                             head;
  logic [$clog2(`EVENT_FIFO_DEPTH):0] fifo_count;
  logic                               overflow;
  logic                               trig_done;
  logic                               arm_start;
  logic                               pop;

  // armed doubles as the internal arm level
  trace_regs u_regs (
    .arm (armed),
    .*
  );

  trace_matcher u_matcher (
    .arm (armed),
    .*
  );

  trace_trigger u_trigger (.*);

  event_fifo #(
    .DEPTH (`EVENT_FIFO_DEPTH)
  ) u_fifo (.*);

endmodule

/* src/event_fifo.sv */
`include "trace_cfg.svh"

module event_fifo #(
  parameter int DEPTH = `EVENT_FIFO_DEPTH
) (
  input  logic                   trace_clk,
  input  logic                   reset,
  input  trace_pkg::rule_mask_t  match_hit,
  input  logic                   arm_start,
  input  logic                   pop,
  output trace_pkg::event_t      head,
  output logic [$clog2(DEPTH):0] fifo_count,
  output logic                   overflow
);
  import trace_pkg::*;

  localparam int PTR_BITS = $clog2(DEPTH);
  localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(DEPTH);

  event_t              mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  timestamp_t          ts_count;
  rule_id_t            hit_id;
  logic                full;
  logic                push;
  logic                do_pop;

  // lowest numbered rule wins
  always_comb begin
    hit_id = '0;
    for (int i = `MATCH_RULES - 1; i >= 0; i--) begin
      if (match_hit[i]) begin
        hit_id = rule_id_t'(i);
      end
    end
  end

  assign full   = (fifo_count == FULL_COUNT);
  assign push   = (|match_hit) & ~full;
  assign do_pop = pop & (fifo_count != '0);
  assign head   = mem[rd_ptr];

  always_ff @(posedge trace_clk) begin
    if (push) begin
      mem[wr_ptr] <= '{rule_id: hit_id, timestamp: ts_count};
    end
  end

  always_ff @(posedge trace_clk) begin
    if (reset || arm_start) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
      overflow   <= 1'b0;
      ts_count   <= '0;
    end else begin
      ts_count <= ts_count + 1'b1;  // free running, wraps
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !do_pop) begin
        fifo_count <= fifo_count + 1'b1;
      end else if (do_pop && !push) begin
        fifo_count <= fifo_count - 1'b1;
      end
      if ((|match_hit) && full) begin
        overflow <= 1'b1;  // sticky until next arm
      end
    end
  end

endmodule

/* src/trace_trigger.sv */
module trace_trigger (
  input  logic                   trace_clk,
  input  logic                   reset,
  input  trace_pkg::rule_mask_t  match_hit,
  input  trace_pkg::rule_mask_t  trig_en,
  input  trace_pkg::trig_delay_t trig_delay,
  input  trace_pkg::trig_width_t trig_width,
  input  logic                   arm_start,
  output logic                   trig_out,
  output logic                   trig_done
);
  import trace_pkg::*;

  trig_state_e state;
  trig_delay_t cnt;         // delay count, then pulse count
  trig_delay_t pulse_last;

  // zero width still gives a one-cycle pulse
  assign pulse_last = (trig_width == '0) ? '0 : trig_delay_t'(trig_width - 1'b1);

  always_ff @(posedge trace_clk) begin
    if (reset || arm_start) begin
      state <= TRIG_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        TRIG_IDLE: begin
          if (|(match_hit & trig_en)) begin
            state <= TRIG_DELAY;
          end
        end
        TRIG_DELAY: begin
          if (cnt == trig_delay) begin
            state <= TRIG_PULSE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        TRIG_PULSE: begin
          if (cnt == pulse_last) begin
            state <= TRIG_DONE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: ;  // done, wait for re-arm
      endcase
    end
  end

  assign trig_out  = (state == TRIG_PULSE);
  assign trig_done = (state == TRIG_DONE);

endmodule

/* src/trace_matcher.sv */
`include "trace_cfg.svh"

module trace_matcher (
  input  logic                                       trace_clk,
  input  logic                                       reset,
  input  trace_pkg::trace_nibble_t                   trace_data,
  input  trace_pkg::rule_cfg_t [`MATCH_RULES-1:0]    rule_cfg,
  input  trace_pkg::rule_mask_t                      rule_en,
  input  logic                                       arm,
  input  logic                                       arm_start,
  output trace_pkg::rule_mask_t                      match_hit,
  output trace_pkg::match_count_t [`MATCH_RULES-1:0] counts
);
  import trace_pkg::*;

  trace_buf_t history;
  rule_mask_t rule_eq;

  // newest nibble at the bottom, oldest falls off the top
  always_ff @(posedge trace_clk) begin
    history <= {history[`TRACE_BUFFER_BITS-`TRACE_LANES-1:0], trace_data};
  end

  always_comb begin
    for (int i = 0; i < `MATCH_RULES; i++) begin
      rule_eq[i] = ((history ^ rule_cfg[i].pattern) & rule_cfg[i].mask) == '0;
    end
  end

  // registered compare, one cycle per hit
  always_ff @(posedge trace_clk) begin
    if (reset) begin
      match_hit <= '0;
    end else begin
      match_hit <= rule_eq & rule_en & {`MATCH_RULES{arm}};
    end
  end

  always_ff @(posedge trace_clk) begin
    if (reset || arm_start) begin
      counts <= '0;
    end else begin
      for (int i = 0; i < `MATCH_RULES; i++) begin
        if (match_hit[i] && counts[i] != '1) begin  // saturates at all ones
          counts[i] <= counts[i] + 1'b1;
        end
      end
    end
  end

endmodule

/* src/trace_regs.sv */
`include "trace_cfg.svh"

module trace_regs (
  input  logic                                       trace_clk,
  input  logic                                       reset,
  input  trace_pkg::apb_req_t                        apb,
  input  trace_pkg::match_count_t [`MATCH_RULES-1:0] counts,
  input  trace_pkg::event_t                          head,
  input  logic [$clog2(`EVENT_FIFO_DEPTH):0]         fifo_count,
  input  logic                                       overflow,
  input  logic                                       trig_done,
  output trace_pkg::apb_rsp_t                        apb_rsp,
  output trace_pkg::rule_cfg_t [`MATCH_RULES-1:0]    rule_cfg,
  output trace_pkg::rule_mask_t                      rule_en,
  output trace_pkg::rule_mask_t                      trig_en,
  output trace_pkg::trig_delay_t                     trig_delay,
  output trace_pkg::trig_width_t                     trig_width,
  output logic                                       arm,
  output logic                                       arm_start,
  output logic                                       pop
);
  import trace_pkg::*;

  logic       access;
  logic       wr;
  logic       rd;
  logic       addr_ok;
  logic       read_only;
  apb_data_t  rdata;
  rule_mask_t pat_sel;
  rule_mask_t mask_sel;

  assign access = apb.psel & apb.penable;  // no wait states
  assign wr     = access & apb.pwrite;
  assign rd     = access & ~apb.pwrite;

  always_comb begin
    rdata     = '0;
    addr_ok   = 1'b1;
    read_only = 1'b0;
    pat_sel   = '0;
    mask_sel  = '0;
    case (apb.paddr)
      `REG_CTRL:       rdata[0] = arm;
      `REG_RULE_EN:    rdata[2*`MATCH_RULES-1:0] = {trig_en, rule_en};
      `REG_TRIG_DELAY: rdata[`TRIG_DELAY_BITS-1:0] = trig_delay;
      `REG_TRIG_WIDTH: rdata[`TRIG_WIDTH_BITS-1:0] = trig_width;
      `REG_STATUS: begin
        read_only = 1'b1;
        rdata[$bits(fifo_count)-1:0] = fifo_count;
        rdata[8] = overflow;
        rdata[9] = trig_done;
      end
      `REG_FIFO_DATA: begin
        read_only = 1'b1;
        if (fifo_count != '0) begin
          rdata[$bits(event_t)-1:0] = head;  // empty fifo reads as zero
        end
      end
      default: begin
        addr_ok = 1'b0;
        // per-rule windows
        for (int i = 0; i < `MATCH_RULES; i++) begin
          if (apb.paddr == apb_addr_t'(`REG_PATTERN_BASE + 8 * i)) begin
            addr_ok    = 1'b1;
            pat_sel[i] = 1'b1;
            rdata      = rule_cfg[i].pattern;
          end
          if (apb.paddr == apb_addr_t'(`REG_MASK_BASE + 8 * i)) begin
            addr_ok     = 1'b1;
            mask_sel[i] = 1'b1;
            rdata       = rule_cfg[i].mask;
          end
          if (apb.paddr == apb_addr_t'(`REG_COUNT_BASE + 4 * i)) begin
            addr_ok   = 1'b1;
            read_only = 1'b1;
            rdata     = apb_data_t'(counts[i]);
          end
        end
      end
    endcase
  end

  assign apb_rsp = '{prdata: rdata, pready: 1'b1,
                     pslverr: access & (~addr_ok | (apb.pwrite & read_only))};
  assign pop = rd & (apb.paddr == `REG_FIFO_DATA) & (fifo_count != '0);

  always_ff @(posedge trace_clk) begin
    if (reset) begin
      arm        <= 1'b0;
      arm_start  <= 1'b0;
      rule_en    <= '0;
      trig_en    <= '0;
      trig_delay <= '0;
      trig_width <= '0;
    end else begin
      arm_start <= 1'b0;
      if (wr) begin
        case (apb.paddr)
          `REG_CTRL: begin
            arm       <= apb.pwdata[0];
            arm_start <= apb.pwdata[0] & ~arm;  // rising arm only
          end
          `REG_RULE_EN:    {trig_en, rule_en} <= apb.pwdata[2*`MATCH_RULES-1:0];
          `REG_TRIG_DELAY: trig_delay <= apb.pwdata[`TRIG_DELAY_BITS-1:0];
          `REG_TRIG_WIDTH: trig_width <= apb.pwdata[`TRIG_WIDTH_BITS-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge trace_clk) begin
    for (int i = 0; i < `MATCH_RULES; i++) begin
      if (wr && pat_sel[i]) begin
        rule_cfg[i].pattern <= apb.pwdata;
      end
      if (wr && mask_sel[i]) begin
        rule_cfg[i].mask <= apb.pwdata;
      end
    end
  end

endmodule

/* src/trace_pkg.sv */
`include "trace_cfg.svh"

package trace_pkg;

  typedef logic [`TRACE_LANES-1:0]         trace_nibble_t;
  typedef logic [`TRACE_BUFFER_BITS-1:0]   trace_buf_t;
  typedef logic [`MATCH_RULES-1:0]         rule_mask_t;   // one bit per rule
  typedef logic [`MATCH_COUNT_BITS-1:0]    match_count_t;
  typedef logic [`TIMESTAMP_BITS-1:0]      timestamp_t;   // cycles since arm
  typedef logic [$clog2(`MATCH_RULES)-1:0] rule_id_t;
  typedef logic [`TRIG_DELAY_BITS-1:0]     trig_delay_t;
  typedef logic [`TRIG_WIDTH_BITS-1:0]     trig_width_t;
  typedef logic [`APB_ADDR_BITS-1:0]       apb_addr_t;
  typedef logic [`APB_DATA_BITS-1:0]       apb_data_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  typedef struct packed {
    trace_buf_t pattern;
    trace_buf_t mask;      // 1 = bit takes part in the compare
  } rule_cfg_t;

  // rule id lands in bits 17:16 of FIFO_DATA
  typedef struct packed {
    rule_id_t   rule_id;
    timestamp_t timestamp;
  } event_t;

  typedef enum logic [1:0] {
    TRIG_IDLE,
    TRIG_DELAY,
    TRIG_PULSE,
    TRIG_DONE
  } trig_state_e;

endpackage

/* src/trace_cfg.svh */
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

`define TRACE_LANES       4    // trace pins sampled per cycle
`define TRACE_BUFFER_BITS 32   // eight nibbles of history
`define MATCH_RULES       4
`define MATCH_COUNT_BITS  8
`define TIMESTAMP_BITS    16
`define EVENT_FIFO_DEPTH  16   // must stay a power of two
`define APB_ADDR_BITS     8
`define APB_DATA_BITS     32
`define TRIG_DELAY_BITS   16
`define TRIG_WIDTH_BITS   12

// register map, byte offsets
`define REG_CTRL          8'h00
`define REG_RULE_EN       8'h04
`define REG_TRIG_DELAY    8'h08
`define REG_TRIG_WIDTH    8'h0C
`define REG_STATUS        8'h10
`define REG_FIFO_DATA     8'h14
`define REG_PATTERN_BASE  8'h20  // pattern i at +8i
`define REG_MASK_BASE     8'h24  // mask i at +8i
`define REG_COUNT_BASE    8'h40  // count i at +4i

`endif
